// File: Makefile
VERILATOR ?= verilator
TOP       ?= tensor_core_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/tensor_config.svh
`ifndef TENSOR_CONFIG_SVH
`define TENSOR_CONFIG_SVH

// warps sharing the block
`define TC_NUM_WARPS 4
// warp index width
`define TC_WID_W 2

// lanes in the single octet
`define TC_NUM_LANES 8
// lane word width
`define TC_DATA_W 32

// writeback register and uop tag widths
`define TC_RD_W 5
`define TC_TAG_W 8

// register stages in the dot unit
`define TC_DOT_LATENCY 2
// result buffer entries
`define TC_RESULT_DEPTH 2
// metadata entries per warp, twice the dot latency
`define TC_META_DEPTH 4

`endif

// File: common/tensor_pkg.sv
`default_nettype none

`include "tensor_config.svh"

package tensor_pkg;

    // one lane word
    typedef logic [`TC_DATA_W-1:0] word_t;
    typedef logic [`TC_WID_W-1:0] wid_t;
    // step within the 4x4x4 operation, two bits
    typedef logic [1:0] step_t;

    // operand row of the octet, seen flat or as two threadgroups
    // threadgroup 0 holds lanes 0-3, threadgroup 1 holds lanes 4-7
    typedef union packed {
        word_t [`TC_NUM_LANES-1:0] lanes;
        word_t [1:0][`TC_NUM_LANES/2-1:0] groups;
    } operand_bus_u;

    // one column of A, rows 0-3
    typedef word_t [3:0] half_a_t;
    // one row of B, columns 0-3
    typedef word_t [3:0] half_b_t;
    // interleaved C elements, one per lane
    typedef word_t [`TC_NUM_LANES-1:0] half_c_t;

    // A indexed [row][k]
    typedef word_t [3:0][1:0] tile_a_t;
    // B indexed [k][col]
    typedef word_t [1:0][3:0] tile_b_t;
    // C and D indexed [row][col]
    typedef word_t [3:0][3:0] tile_d_t;

    // per-uop writeback info kept until commit
    typedef struct packed {
        logic [`TC_RD_W-1:0] rd;
        logic [`TC_TAG_W-1:0] tag;
    } meta_t;

endpackage

`default_nettype wire

// File: rtl/tensor_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "tensor_config.svh"

module tensor_core (
    input  wire                           clk,
    input  wire                           reset,

    // dispatch
    input  wire                           in_valid,
    input  wire tensor_pkg::wid_t         in_wid,
    input  wire tensor_pkg::step_t        in_step,
    input  wire                           in_last_in_pair,
    input  wire [`TC_RD_W-1:0]            in_rd,
    input  wire [`TC_TAG_W-1:0]           in_tag,
    input  wire tensor_pkg::operand_bus_u in_a,
    input  wire tensor_pkg::operand_bus_u in_b,
    input  wire tensor_pkg::operand_bus_u in_c,
    output logic                          in_ready,

    // commit
    output logic                          out_valid,
    output tensor_pkg::wid_t              out_wid,
    output logic [`TC_RD_W-1:0]           out_rd,
    output logic [`TC_TAG_W-1:0]          out_tag,
    output tensor_pkg::operand_bus_u      out_data,
    input  wire                           out_ready
);

    // operand stage to writeback metadata
    logic                meta_push;
    logic                meta_full;
    tensor_pkg::wid_t    meta_wid;
    tensor_pkg::meta_t   meta_in;

    // tile issue
    logic                hmma_valid;
    logic                hmma_ready;
    tensor_pkg::tile_a_t hmma_a;
    tensor_pkg::tile_b_t hmma_b;
    tensor_pkg::tile_d_t hmma_c;
    tensor_pkg::wid_t    hmma_wid;

    // dot result into the result buffer
    logic                dot_valid;
    logic                buf_ready;
    tensor_pkg::tile_d_t dot_d;
    tensor_pkg::wid_t    dot_wid;

    tensor_operand_stage operand_stage_inst (
        .clk, .reset,
        .in_valid, .in_wid, .in_step, .in_last_in_pair,
        .in_rd, .in_tag, .in_a, .in_b, .in_c, .in_ready,
        .meta_full, .meta_push, .meta_wid, .meta_in,
        .hmma_valid, .hmma_a, .hmma_b, .hmma_c, .hmma_wid, .hmma_ready
    );

    tensor_dot_unit dot_unit_inst (
        .clk, .reset,
        .hmma_valid, .hmma_a, .hmma_b, .hmma_c, .hmma_wid, .hmma_ready,
        .dot_valid, .dot_d, .dot_wid, .buf_ready
    );

    tensor_writeback writeback_inst (
        .clk, .reset,
        .dot_valid, .dot_d, .dot_wid, .buf_ready,
        .meta_push, .meta_wid, .meta_in, .meta_full,
        .out_valid, .out_wid, .out_rd, .out_tag, .out_data, .out_ready
    );

endmodule

`default_nettype wire

// File: rtl/tensor_dot_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "tensor_config.svh"

module tensor_dot_unit (
    input  wire                        clk,
    input  wire                        reset,

    input  wire                        hmma_valid,
    input  wire tensor_pkg::tile_a_t   hmma_a,
    input  wire tensor_pkg::tile_b_t   hmma_b,
    input  wire tensor_pkg::tile_d_t   hmma_c,
    input  wire tensor_pkg::wid_t      hmma_wid,
    output logic                       hmma_ready,

    output logic                       dot_valid,
    output tensor_pkg::tile_d_t        dot_d,
    output tensor_pkg::wid_t           dot_wid,
    input  wire                        buf_ready
);

    localparam int LAT = `TC_DOT_LATENCY;

    // one valid bit and warp id per stage
    logic [LAT-1:0]      stage_valid;
    tensor_pkg::wid_t    stage_wid [LAT];

    // first stage keeps C plus the k=0 products, and the k=1 products apart
    tensor_pkg::tile_d_t part_d;
    tensor_pkg::tile_d_t prod_d;
    tensor_pkg::tile_d_t part_q;
    tensor_pkg::tile_d_t prod_q;
    tensor_pkg::tile_d_t sum_d;
    // finished D from stage 1 onward
    tensor_pkg::tile_d_t d_pipe [1:LAT-1];

    logic advance;

    // whole pipe freezes when the tail result has nowhere to go
    assign advance    = !(stage_valid[LAT-1] && !buf_ready);
    assign hmma_ready = advance;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                // integer math, wraps modulo 2^32
                part_d[i][j] = hmma_c[i][j] + hmma_a[i][0] * hmma_b[0][j];
                prod_d[i][j] = hmma_a[i][1] * hmma_b[1][j];
                sum_d[i][j]  = part_q[i][j] + prod_q[i][j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[LAT-2:0], hmma_valid};
        end
    end

    // payload moves with the valid bits, no reset needed
    always_ff @(posedge clk) begin
        if (advance) begin
            part_q       <= part_d;
            prod_q       <= prod_d;
            stage_wid[0] <= hmma_wid;
            d_pipe[1]    <= sum_d;
            // extra stages only delay the result
            for (int s = 2; s < LAT; s++) begin
                d_pipe[s] <= d_pipe[s-1];
            end
            for (int s = 1; s < LAT; s++) begin
                stage_wid[s] <= stage_wid[s-1];
            end
        end
    end

    assign dot_valid = stage_valid[LAT-1];
    assign dot_d     = d_pipe[LAT-1];
    assign dot_wid   = stage_wid[LAT-1];

endmodule

`default_nettype wire

// File: rtl/tensor_operand_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "tensor_config.svh"

module tensor_operand_stage (
    input  wire                       clk,
    input  wire                       reset,

    input  wire                       in_valid,
    input  wire tensor_pkg::wid_t     in_wid,
    input  wire tensor_pkg::step_t    in_step,
    input  wire                       in_last_in_pair,
    input  wire [`TC_RD_W-1:0]        in_rd,
    input  wire [`TC_TAG_W-1:0]       in_tag,
    input  wire tensor_pkg::operand_bus_u in_a,
    input  wire tensor_pkg::operand_bus_u in_b,
    input  wire tensor_pkg::operand_bus_u in_c,
    output logic                      in_ready,

    input  wire                       meta_full,
    output logic                      meta_push,
    output tensor_pkg::wid_t          meta_wid,
    output tensor_pkg::meta_t         meta_in,

    output logic                      hmma_valid,
    output tensor_pkg::tile_a_t       hmma_a,
    output tensor_pkg::tile_b_t       hmma_b,
    output tensor_pkg::tile_d_t       hmma_c,
    output tensor_pkg::wid_t          hmma_wid,
    input  wire                       hmma_ready
);

    // halves picked from the current dispatch
    tensor_pkg::half_a_t cur_a;
    tensor_pkg::half_b_t cur_b;
    tensor_pkg::half_c_t cur_c;

    // first-substep halves, one set per warp
    tensor_pkg::half_a_t stage_a [`TC_NUM_WARPS];
    tensor_pkg::half_b_t stage_b [`TC_NUM_WARPS];
    tensor_pkg::half_c_t stage_c [`TC_NUM_WARPS];

    logic accept;
    logic first_fire;

    // dot unit and metadata queues both have to take the uop
    assign in_ready   = hmma_ready && !meta_full;
    assign accept     = in_valid && in_ready;
    assign first_fire = accept && !in_last_in_pair;

    // every accepted uop gets a metadata entry, first substeps included
    assign meta_push  = accept;
    assign meta_wid   = in_wid;
    assign meta_in    = '{rd: in_rd, tag: in_tag};

    always_comb begin
        // step bit 0 selects the k column pair inside each threadgroup
        if (in_step[0]) begin
            cur_a = {in_a.groups[1][3:2], in_a.groups[0][3:2]};
        end else begin
            cur_a = {in_a.groups[1][1:0], in_a.groups[0][1:0]};
        end
        // B row is shared by both threadgroups
        // step bit 1 picks which threadgroup supplies it
        if (in_step[1]) begin
            cur_b = in_b.groups[1];
        end else begin
            cur_b = in_b.groups[0];
        end
        // every lane carries one C element
        cur_c = in_c.lanes;
    end

    // staging write on the first substep of a pair
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `TC_NUM_WARPS; w++) begin
                stage_a[w] <= '0;
                stage_b[w] <= '0;
                stage_c[w] <= '0;
            end
        end else if (first_fire) begin
            stage_a[in_wid] <= cur_a;
            stage_b[in_wid] <= cur_b;
            stage_c[in_wid] <= cur_c;
        end
    end

    // second substep issues straight from the ports plus the staged halves
    assign hmma_valid = accept && in_last_in_pair;
    assign hmma_wid   = in_wid;

    always_comb begin
        int base;
        base = 0;
        // A joins stored and current columns along k
        for (int r = 0; r < 4; r++) begin
            hmma_a[r][0] = stage_a[in_wid][r];
            hmma_a[r][1] = cur_a[r];
        end
        // stored row is k=0, current row is k=1
        hmma_b[0] = stage_b[in_wid];
        hmma_b[1] = cur_b;
        // jagged 1x2 layout, each lane owns a stored/current pair in one row
        // rows 0,1 come from lanes 0-3 and rows 2,3 from lanes 4-7
        for (int r = 0; r < 4; r++) begin
            base = (r / 2) * 4 + (r % 2);
            hmma_c[r][0] = stage_c[in_wid][base];
            hmma_c[r][1] = cur_c[base];
            hmma_c[r][2] = stage_c[in_wid][base + 2];
            hmma_c[r][3] = cur_c[base + 2];
        end
    end

endmodule

`default_nettype wire

// File: rtl/tensor_writeback.sv
`timescale 1ns/10ps
`default_nettype none

`include "tensor_config.svh"

module tensor_writeback (
    input  wire                           clk,
    input  wire                           reset,

    input  wire                           dot_valid,
    input  wire tensor_pkg::tile_d_t      dot_d,
    input  wire tensor_pkg::wid_t         dot_wid,
    output logic                          buf_ready,

    input  wire                           meta_push,
    input  wire tensor_pkg::wid_t         meta_wid,
    input  wire tensor_pkg::meta_t        meta_in,
    output logic                          meta_full,

    output logic                          out_valid,
    output tensor_pkg::wid_t              out_wid,
    output logic [`TC_RD_W-1:0]           out_rd,
    output logic [`TC_TAG_W-1:0]          out_tag,
    output tensor_pkg::operand_bus_u      out_data,
    input  wire                           out_ready
);

    localparam int RES_DEPTH  = `TC_RESULT_DEPTH;
    localparam int RES_PTR_W  = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;
    localparam int RES_CNT_W  = $clog2(RES_DEPTH + 1);
    localparam int META_DEPTH = `TC_META_DEPTH;
    localparam int META_PTR_W = (META_DEPTH > 1) ? $clog2(META_DEPTH) : 1;
    localparam int META_CNT_W = $clog2(META_DEPTH + 1);

    // result FIFO
    tensor_pkg::tile_d_t   res_d   [RES_DEPTH];
    tensor_pkg::wid_t      res_wid [RES_DEPTH];
    logic [RES_PTR_W-1:0]  res_wr_ptr;
    logic [RES_PTR_W-1:0]  res_rd_ptr;
    logic [RES_CNT_W-1:0]  res_count;
    logic                  res_push;
    logic                  res_pop;

    // one metadata FIFO per warp
    tensor_pkg::meta_t     meta_mem    [`TC_NUM_WARPS][META_DEPTH];
    logic [META_PTR_W-1:0] meta_wr_ptr [`TC_NUM_WARPS];
    logic [META_PTR_W-1:0] meta_rd_ptr [`TC_NUM_WARPS];
    logic [META_CNT_W-1:0] meta_count  [`TC_NUM_WARPS];
    logic [`TC_NUM_WARPS-1:0] meta_push_w;
    logic [`TC_NUM_WARPS-1:0] meta_pop_w;
    logic [`TC_NUM_WARPS-1:0] meta_warp_full;

    // 0 while beat 0 is pending, 1 for beat 1
    logic                  subcommit;
    logic                  beat_fire;
    tensor_pkg::tile_d_t   head_d;
    tensor_pkg::meta_t     head_meta;

    assign buf_ready = (res_count != RES_CNT_W'(RES_DEPTH));
    assign out_valid = (res_count != '0);
    assign beat_fire = out_valid && out_ready;
    assign res_push  = dot_valid && buf_ready;
    // entry leaves only after its second beat
    assign res_pop   = beat_fire && subcommit;

    assign head_d  = res_d[res_rd_ptr];
    assign out_wid = res_wid[res_rd_ptr];

    always_comb begin
        for (int w = 0; w < `TC_NUM_WARPS; w++) begin
            meta_push_w[w]    = meta_push && (meta_wid == tensor_pkg::wid_t'(w));
            // one metadata entry per beat of the committing warp
            meta_pop_w[w]     = beat_fire && (out_wid == tensor_pkg::wid_t'(w));
            meta_warp_full[w] = (meta_count[w] == META_CNT_W'(META_DEPTH));
        end
    end

    // any full warp queue stops dispatch for all warps
    assign meta_full = |meta_warp_full;

    // storage writes
    always_ff @(posedge clk) begin
        if (res_push) begin
            res_d[res_wr_ptr]   <= dot_d;
            res_wid[res_wr_ptr] <= dot_wid;
        end
        if (meta_push) begin
            meta_mem[meta_wid][meta_wr_ptr[meta_wid]] <= meta_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_wr_ptr <= '0;
            res_rd_ptr <= '0;
            res_count  <= '0;
            subcommit  <= 1'b0;
            for (int w = 0; w < `TC_NUM_WARPS; w++) begin
                meta_wr_ptr[w] <= '0;
                meta_rd_ptr[w] <= '0;
                meta_count[w]  <= '0;
            end
        end else begin
            if (res_push) begin
                res_wr_ptr <= (res_wr_ptr == RES_PTR_W'(RES_DEPTH - 1)) ? '0 : res_wr_ptr + 1'b1;
            end
            if (res_pop) begin
                res_rd_ptr <= (res_rd_ptr == RES_PTR_W'(RES_DEPTH - 1)) ? '0 : res_rd_ptr + 1'b1;
            end
            res_count <= res_count + RES_CNT_W'(res_push) - RES_CNT_W'(res_pop);
            if (beat_fire) begin
                subcommit <= ~subcommit;
            end
            for (int w = 0; w < `TC_NUM_WARPS; w++) begin
                if (meta_push_w[w]) begin
                    meta_wr_ptr[w] <= (meta_wr_ptr[w] == META_PTR_W'(META_DEPTH - 1)) ?
                                      '0 : meta_wr_ptr[w] + 1'b1;
                end
                if (meta_pop_w[w]) begin
                    meta_rd_ptr[w] <= (meta_rd_ptr[w] == META_PTR_W'(META_DEPTH - 1)) ?
                                      '0 : meta_rd_ptr[w] + 1'b1;
                end
                meta_count[w] <= meta_count[w] + META_CNT_W'(meta_push_w[w])
                                 - META_CNT_W'(meta_pop_w[w]);
            end
        end
    end

    assign head_meta = meta_mem[out_wid][meta_rd_ptr[out_wid]];
    assign out_rd    = head_meta.rd;
    assign out_tag   = head_meta.tag;

    // jagged lane map, beat 0 takes columns 0 and 2, beat 1 columns 1 and 3
    always_comb begin
        int col;
        col = int'(subcommit);
        for (int g = 0; g < 2; g++) begin
            // threadgroup g owns rows 2g and 2g+1
            out_data.groups[g][0] = head_d[2*g][col];
            out_data.groups[g][1] = head_d[2*g+1][col];
            out_data.groups[g][2] = head_d[2*g][col+2];
            out_data.groups[g][3] = head_d[2*g+1][col+2];
        end
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+common
common/tensor_pkg.sv
rtl/tensor_operand_stage.sv
rtl/tensor_dot_unit.sv
rtl/tensor_writeback.sv
rtl/tensor_core.sv
sim/tensor_core_assert.sv
sim/tensor_core_tb.sv

// File: sim/tensor_core_assert.sv
`timescale 1ns/10ps
`default_nettype none

`include "tensor_config.svh"

module tensor_core_assert (
    input wire                           clk,
    input wire                           reset,
    input wire                           in_ready,
    input wire                           meta_full,
    input wire                           dot_valid,
    input wire                           buf_ready,
    input wire                           out_valid,
    input wire                           out_ready,
    input wire tensor_pkg::wid_t         out_wid,
    input wire [`TC_RD_W-1:0]            out_rd,
    input wire [`TC_TAG_W-1:0]           out_tag,
    input wire tensor_pkg::operand_bus_u out_data
);

    // result buffer empty during reset and on the cycle after it
    idle_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high right after a reset cycle");

    // a stalled beat keeps its warp, metadata and lanes
    hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_wid) && $stable(out_rd)
            && $stable(out_tag) && $stable(out_data))
        else $error("commit outputs changed while out_ready was low");

    // a frozen dot pipeline cannot take a tile, so dispatch is held off
    stall_blocks_dispatch: assert property (@(posedge clk) disable iff (reset)
        dot_valid && !buf_ready |-> !in_ready)
        else $error("in_ready high while the dot unit was stalled");

    full_blocks_dispatch: assert property (@(posedge clk) disable iff (reset)
        meta_full |-> !in_ready)
        else $error("in_ready high with a full metadata queue");

endmodule

bind tensor_core tensor_core_assert tensor_core_assert_inst (
    .clk, .reset, .in_ready, .meta_full, .dot_valid, .buf_ready,
    .out_valid, .out_ready, .out_wid, .out_rd, .out_tag, .out_data
);

`default_nettype wire

// File: sim/tensor_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "tensor_config.svh"

module tensor_core_tb;

    // 76 uops plus a 24-cycle hold, each uop well under 25 cycles, about double for margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int HOLD_CYCLES = 24;

    // one expected commit beat
    typedef struct packed {
        tensor_pkg::wid_t         wid;
        logic [`TC_RD_W-1:0]      rd;
        logic [`TC_TAG_W-1:0]     tag;
        tensor_pkg::operand_bus_u data;
    } beat_t;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     in_valid;
    tensor_pkg::wid_t         in_wid;
    tensor_pkg::step_t        in_step;
    logic                     in_last_in_pair;
    logic [`TC_RD_W-1:0]      in_rd;
    logic [`TC_TAG_W-1:0]     in_tag;
    tensor_pkg::operand_bus_u in_a;
    tensor_pkg::operand_bus_u in_b;
    tensor_pkg::operand_bus_u in_c;
    logic                     in_ready;
    logic                     out_valid;
    tensor_pkg::wid_t         out_wid;
    logic [`TC_RD_W-1:0]      out_rd;
    logic [`TC_TAG_W-1:0]     out_tag;
    tensor_pkg::operand_bus_u out_data;
    logic                     out_ready;

    // first-substep halves and metadata per warp for the reference model
    tensor_pkg::word_t st_a [`TC_NUM_WARPS][4];
    tensor_pkg::word_t st_b [`TC_NUM_WARPS][4];
    tensor_pkg::word_t st_c [`TC_NUM_WARPS][8];
    tensor_pkg::meta_t st_meta [`TC_NUM_WARPS];
    beat_t             exp_q [$];

    // 0 always ready, 1 random stalls, 2 held low
    int          ready_mode;
    int          cycles = 0;
    int          test_errors;
    int          total_errors;
    int          tests_clean;
    int          tests_bad;
    string       test_name;
    logic [31:0] seed_ret;

    tensor_core tensor_core_inst (
        .clk, .reset, .in_valid, .in_wid, .in_step, .in_last_in_pair, .in_rd, .in_tag,
        .in_a, .in_b, .in_c, .in_ready,
        .out_valid, .out_wid, .out_rd, .out_tag, .out_data, .out_ready
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // commit side samples settled outputs on the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            out_ready = (ready_mode == 0) || (ready_mode == 1 && $urandom() % 2 == 0);
            if (out_valid && out_ready) begin
                check_beat();
            end
        end
    end

    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            tests_clean++;
            $display("test %s: ok", test_name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    // reference model of half selection, tile joining, math and lane map
    task automatic model_accept(input tensor_pkg::wid_t w, input tensor_pkg::step_t s,
                                input tensor_pkg::meta_t m, input tensor_pkg::operand_bus_u a,
                                input tensor_pkg::operand_bus_u b,
                                input tensor_pkg::operand_bus_u c);
        tensor_pkg::word_t ha [4];
        tensor_pkg::word_t hb [4];
        tensor_pkg::word_t tc [4][4];
        tensor_pkg::word_t td [4][4];
        beat_t             bt;
        int                lb;
        for (int k = 0; k < 4; k++) begin
            // A from lanes 0,1,4,5 or 2,3,6,7
            ha[k] = a.lanes[(k / 2) * 4 + (k % 2) + (s[0] ? 2 : 0)];
            // B from lanes 0-3 or 4-7
            hb[k] = b.lanes[k + (s[1] ? 4 : 0)];
        end
        if (!s[0]) begin
            st_a[w] = ha;
            st_b[w] = hb;
            for (int l = 0; l < 8; l++) begin
                st_c[w][l] = c.lanes[l];
            end
            st_meta[w] = m;
        end else begin
            // jagged C takes rows 0,1 from lanes 0-3 and rows 2,3 from lanes 4-7
            for (int r = 0; r < 4; r++) begin
                lb = (r < 2) ? r : r + 2;
                tc[r][0] = st_c[w][lb];
                tc[r][1] = c.lanes[lb];
                tc[r][2] = st_c[w][lb + 2];
                tc[r][3] = c.lanes[lb + 2];
            end
            // stored half is k=0, current half is k=1
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    td[i][j] = tc[i][j] + st_a[w][i] * st_b[w][j] + ha[i] * hb[j];
                end
            end
            for (int beat = 0; beat < 2; beat++) begin
                bt.wid = w;
                bt.rd  = (beat == 0) ? st_meta[w].rd : m.rd;
                bt.tag = (beat == 0) ? st_meta[w].tag : m.tag;
                // threadgroup picks the row pair, lane bit 1 the column pair
                for (int l = 0; l < 8; l++) begin
                    bt.data.lanes[l] = td[2 * (l / 4) + (l % 2)][beat + 2 * ((l % 4) / 2)];
                end
                exp_q.push_back(bt);
            end
        end
    endtask

    // called on a falling edge, returns one falling edge after the accepting edge
    task automatic send_uop(input tensor_pkg::wid_t w, input tensor_pkg::step_t s);
        tensor_pkg::operand_bus_u a;
        tensor_pkg::operand_bus_u b;
        tensor_pkg::operand_bus_u c;
        logic [31:0]              r;
        for (int l = 0; l < 8; l++) begin
            a.lanes[l] = $urandom();
            b.lanes[l] = $urandom();
            c.lanes[l] = $urandom();
        end
        r = $urandom();
        in_valid = 1'b1;
        in_wid = w;
        in_step = s;
        in_last_in_pair = s[0];
        in_rd = r[`TC_RD_W-1:0];
        in_tag = r[8 +: `TC_TAG_W];
        in_a = a;
        in_b = b;
        in_c = c;
        // in_ready depends on state only, so it holds for the coming edge
        while (!in_ready) @(negedge clk);
        model_accept(w, s, '{rd: in_rd, tag: in_tag}, a, b, c);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic check_beat();
        beat_t want;
        beat_t got;
        got = '{wid: out_wid, rd: out_rd, tag: out_tag, data: out_data};
        assert (exp_q.size() != 0) else begin
            $display("%s: commit beat seen with no result outstanding", test_name);
            note_error();
        end
        if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            assert (got == want) else begin
                $write("FAIL %s expected wid %0d rd %0d tag %0d data %h",
                       test_name, want.wid, want.rd, want.tag, want.data);
                $display(" actual wid %0d rd %0d tag %0d data %h",
                         got.wid, got.rd, got.tag, got.data);
                note_error();
            end
        end
    endtask

    task automatic wait_drain();
        @(negedge clk);
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        assert (!out_valid) else begin
            $display("%s: a result is left in the commit path", test_name);
            note_error();
        end
    endtask

    // first substeps of other warps sit between each warp's pair
    task automatic run_interleaved(input tensor_pkg::wid_t w0, input tensor_pkg::wid_t w1,
                                   input tensor_pkg::wid_t w2);
        tensor_pkg::step_t s_first;
        for (int h = 0; h < 2; h++) begin
            s_first = tensor_pkg::step_t'(2 * h);
            send_uop(w0, s_first);
            send_uop(w1, s_first);
            send_uop(w0, s_first + 2'd1);
            send_uop(w2, s_first);
            send_uop(w1, s_first + 2'd1);
            send_uop(w2, s_first + 2'd1);
        end
    endtask

    // waits for in_ready to drop, then checks the block holds off dispatch
    task automatic hold_and_release();
        @(negedge clk);
        while (in_ready) @(negedge clk);
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            assert (!in_ready) else begin
                $display("%s: in_ready rose while commits were blocked", test_name);
                note_error();
            end
        end
        ready_mode = 0;
    endtask

    initial begin
        seed_ret = $urandom(32'ha1fa_3877);
        reset = 1'b1;
        in_valid = 1'b0;
        in_wid = '0;
        in_step = '0;
        in_last_in_pair = 1'b0;
        in_rd = '0;
        in_tag = '0;
        in_a = '0;
        in_b = '0;
        in_c = '0;
        out_ready = 1'b1;
        ready_mode = 0;
        total_errors = 0;
        tests_clean = 0;
        tests_bad = 0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        start_test("reset_state");
        assert (out_valid == 1'b0) else begin
            $display("FAIL %s out_valid expected 0 actual %0b", test_name, out_valid);
            note_error();
        end
        assert (in_ready == 1'b1) else begin
            $display("FAIL %s in_ready expected 1 actual %0b", test_name, in_ready);
            note_error();
        end
        end_test();

        start_test("single_warp_steps");
        for (int round = 0; round < 2; round++) begin
            for (int s = 0; s < 4; s++) begin
                send_uop(2'd0, tensor_pkg::step_t'(s));
            end
        end
        wait_drain();
        end_test();

        start_test("interleaved_warps");
        run_interleaved(2'd0, 2'd1, 2'd2);
        wait_drain();
        end_test();

        start_test("random_backpressure");
        ready_mode = 1;
        for (int round = 0; round < 4; round++) begin
            run_interleaved(tensor_pkg::wid_t'(round), tensor_pkg::wid_t'(round + 1),
                            tensor_pkg::wid_t'(round + 2));
        end
        ready_mode = 0;
        wait_drain();
        end_test();

        start_test("full_stall_release");
        ready_mode = 2;
        fork
            begin
                for (int p = 0; p < 2; p++) begin
                    for (int s = 0; s < 4; s++) begin
                        send_uop(2'd3, tensor_pkg::step_t'(s));
                    end
                end
            end
            hold_and_release();
        join
        wait_drain();
        end_test();

        $display("summary: %0d tests, %0d clean, %0d with errors, %0d errors in all",
                 tests_clean + tests_bad, tests_clean, tests_bad, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
